// ==== alu_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_logic import exe_pkg::*; (
    input  alu_op_e     op,
    input  logic [31:0] src_a,
    input  logic [31:0] src_b,
    input  logic [4:0]  sa,
    input  logic        llbit,
    output logic [31:0] result,
    output logic        overflow,
    output logic        trap
);

    logic        sub_mode;
    logic [31:0] b_eff;
    logic [31:0] sum;
    logic        cout;
    logic        lt_s;
    logic        lt_u;
    logic        eq;
    logic [4:0]  shamt;
    logic [31:0] cnt_src;
    logic [5:0]  lead;

    // compares and traps reuse the adder as a - b
    assign sub_mode = op inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU, OP_TEQ, OP_TNE,
                                 OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    assign b_eff = src_b ^ {32{sub_mode}};
    assign {cout, sum} = {1'b0, src_a} + {1'b0, b_eff} + {32'd0, sub_mode};

    assign lt_s = (src_a[31] & ~src_b[31]) | (~(src_a[31] ^ src_b[31]) & sum[31]);
    assign lt_u = ~cout; // no carry out means borrow
    assign eq   = (sum == 32'd0);

    assign shamt = (op inside {OP_SLLV, OP_SRLV, OP_SRAV}) ? src_a[4:0] : sa;

    assign cnt_src = (op == OP_CLZ) ? src_a : ~src_a;

    always_comb begin
        lead = 6'd32;
        for (int i = 0; i < 32; i++) begin
            if (cnt_src[i]) begin
                lead = 6'(31 - i); // highest set bit wins
            end
        end
    end

    always_comb begin
        case (op)
            OP_AND:                     result = src_a & src_b;
            OP_OR:                      result = src_a | src_b;
            OP_NOR:                     result = ~(src_a | src_b);
            OP_XOR:                     result = src_a ^ src_b;
            OP_ADD, OP_ADDU,
            OP_SUB, OP_SUBU:            result = sum;
            OP_SLT:                     result = {31'd0, lt_s};
            OP_SLTU:                    result = {31'd0, lt_u};
            OP_SLL, OP_SLLV:            result = src_b << shamt;
            OP_SRL, OP_SRLV:            result = src_b >> shamt;
            OP_SRA, OP_SRAV:            result = $signed(src_b) >>> shamt;
            OP_LUI:                     result = {src_b[15:0], 16'd0};
            OP_PASS:                    result = src_a;
            OP_CLO, OP_CLZ:             result = {26'd0, lead};
            OP_SC:                      result = {31'd0, llbit};
            default:                    result = 32'd0;
        endcase
    end

    // signed overflow only for the trapping add and sub
    assign overflow = (op inside {OP_ADD, OP_SUB}) &&
                      (src_a[31] == b_eff[31]) && (sum[31] != src_a[31]);

    always_comb begin
        case (op)
            OP_TEQ:  trap = eq;
            OP_TNE:  trap = ~eq;
            OP_TGE:  trap = ~lt_s;
            OP_TGEU: trap = ~lt_u;
            OP_TLT:  trap = lt_s;
            OP_TLTU: trap = lt_u;
            default: trap = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== div_radix2.sv ====
`timescale 1ns/1ps
`default_nettype none

module div_radix2 (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  logic        abort,
    input  logic        sign,
    input  logic [31:0] dividend,
    input  logic [31:0] divisor,
    output logic        busy,
    output logic [63:0] result
);

    logic        run_q;
    logic [5:0]  cnt_q;
    logic        last;
    logic        step_en;
    logic        fix_en;
    logic [31:0] rem_q;
    logic [31:0] quo_q;
    logic [31:0] dvs_q;
    logic        qneg_q;
    logic        rneg_q;
    logic [31:0] cur_rem;
    logic [31:0] cur_quo;
    logic [31:0] cur_dvs;
    logic [32:0] rem_sh;
    logic [32:0] diff;

    assign cur_rem = start ? 32'd0 : rem_q;
    assign cur_quo = start ? ((sign && dividend[31]) ? (~dividend + 32'd1) : dividend) : quo_q;
    assign cur_dvs = start ? ((sign && divisor[31]) ? (~divisor + 32'd1) : divisor) : dvs_q;

    // dividend bits shift in from the quotient register
    assign rem_sh = {cur_rem, cur_quo[31]};
    assign diff   = rem_sh - {1'b0, cur_dvs};

    assign last    = (cnt_q == 6'd32);    // sign fix-up cycle
    assign step_en = start | (run_q & ~last);
    assign fix_en  = run_q & last;
    assign busy    = run_q & ~last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
            cnt_q <= 6'd0;
        end else if (abort) begin
            run_q <= 1'b0;
        end else if (start) begin
            run_q <= 1'b1;
            cnt_q <= 6'd1;
        end else if (run_q) begin
            cnt_q <= cnt_q + 6'd1;
            if (last) run_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (step_en) begin
            rem_q <= diff[32] ? rem_sh[31:0] : diff[31:0];
            quo_q <= {cur_quo[30:0], ~diff[32]};
        end else if (fix_en) begin
            if (rneg_q) rem_q <= ~rem_q + 32'd1;
            if (qneg_q) quo_q <= ~quo_q + 32'd1;
        end
        if (start) begin
            dvs_q  <= cur_dvs;
            qneg_q <= sign & (dividend[31] ^ divisor[31]) & (|divisor); // x/0 keeps all ones
            rneg_q <= sign & dividend[31];
        end
    end

    assign result = {rem_q, quo_q};

endmodule

`default_nettype wire

// ==== exe_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_alu import exe_pkg::*; #(
    parameter int MUL_STEP = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  exe_req_t    req,
    input  logic        flush,
    input  hilo_t       hilo,
    output logic        stall,
    output logic        done,
    output alu_op_e     out_op,
    output logic [63:0] out_result,
    output logic        out_overflow,
    output logic        out_trap
);

    typedef enum logic [1:0] {ST_IDLE, ST_RUN, ST_FINISH} state_e;

    state_e      state_q;
    state_e      state_d;
    logic        long_req;
    logic        mul_op;
    logic        div_op;
    logic        start;
    logic        eng_busy;
    logic        mul_busy;
    logic        div_busy;
    logic [63:0] mul_product;
    logic [63:0] div_result;
    logic [31:0] logic_result;

    assign long_req = req.valid & is_long(req.op);
    assign mul_op   = req.op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU};
    assign div_op   = req.op inside {OP_DIV, OP_DIVU};
    assign start    = (state_q == ST_IDLE) & long_req & ~flush;
    assign eng_busy = div_op ? div_busy : mul_busy;

    always_comb begin
        state_d = state_q;
        stall   = 1'b0;
        case (state_q)
            ST_IDLE: begin
                stall = long_req; // held until the engine is done
                if (start) state_d = ST_RUN;
            end
            ST_RUN: begin
                stall = 1'b1;
                if (flush) state_d = ST_IDLE;
                else if (!eng_busy) state_d = ST_FINISH;
            end
            default: state_d = ST_IDLE; // result is taken in finish
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) state_q <= ST_IDLE;
        else state_q <= state_d;
    end

    assign done = req.valid & ~stall;

    alu_logic alu_logic_i (
        .op       (req.op),
        .src_a    (req.src_a),
        .src_b    (req.src_b),
        .sa       (req.sa),
        .llbit    (req.llbit),
        .result   (logic_result),
        .overflow (out_overflow),
        .trap     (out_trap)
    );

    mult_seq #(.MUL_STEP(MUL_STEP)) mult_seq_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .start   (start & mul_op),
        .abort   (flush),
        .sign    (req.op inside {OP_MULT, OP_MADD, OP_MSUB}),
        .a       (req.src_a),
        .b       (req.src_b),
        .busy    (mul_busy),
        .product (mul_product)
    );

    div_radix2 div_radix2_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start & div_op),
        .abort    (flush),
        .sign     (req.op == OP_DIV),
        .dividend (req.src_a),
        .divisor  (req.src_b),
        .busy     (div_busy),
        .result   (div_result)
    );

    always_comb begin
        case (req.op)
            OP_MULT, OP_MULTU: out_result = mul_product;
            OP_MADD, OP_MADDU: out_result = hilo + mul_product;
            OP_MSUB, OP_MSUBU: out_result = hilo - mul_product;
            OP_DIV, OP_DIVU:   out_result = div_result;
            OP_MTHI:           out_result = {req.src_a, hilo.lo};
            OP_MTLO:           out_result = {hilo.hi, req.src_a};
            default:           out_result = {32'd0, logic_result};
        endcase
    end

    assign out_op = req.op;

    a_short_no_stall: assert property (@(posedge clk) disable iff (!arst_n)
        !(req.valid && is_long(req.op)) |-> !stall);

endmodule

`default_nettype wire

// ==== exe_pkg.sv ====
`default_nettype none

package exe_pkg;

    typedef enum logic [5:0] {
        OP_AND = 6'd0,
        OP_OR,
        OP_NOR,
        OP_XOR,
        OP_ADD,
        OP_ADDU,
        OP_SUB,
        OP_SUBU,
        OP_SLT,
        OP_SLTU,
        OP_SLL,
        OP_SLLV,
        OP_SRL,
        OP_SRLV,
        OP_SRA,
        OP_SRAV,
        OP_LUI,
        OP_PASS,
        OP_CLO,
        OP_CLZ,
        OP_SC,
        OP_TEQ,
        OP_TNE,
        OP_TGE,
        OP_TGEU,
        OP_TLT,
        OP_TLTU,
        OP_MULT,
        OP_MULTU,
        OP_MADD,
        OP_MADDU,
        OP_MSUB,
        OP_MSUBU,
        OP_DIV,
        OP_DIVU,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

    typedef struct packed {
        logic        valid;
        alu_op_e     op;
        logic [31:0] src_a;
        logic [31:0] src_b;
        logic [4:0]  sa;     // immediate shift amount
        logic        llbit;
        logic [2:0]  spare;  // keep zero
    } exe_req_t;

    typedef struct packed {
        logic        valid;
        alu_op_e     op;
        logic [63:0] result;
        logic        overflow;
        logic        trap;
    } exe_resp_t;

    typedef struct packed {
        logic [31:0] hi;
        logic [31:0] lo;
    } hilo_t;

    function automatic logic is_long(alu_op_e op);
        return op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU,
                          OP_MSUB, OP_MSUBU, OP_DIV, OP_DIVU};
    endfunction

    function automatic logic writes_hilo(alu_op_e op);
        return is_long(op) || (op inside {OP_MTHI, OP_MTLO});
    endfunction

endpackage

`default_nettype wire

// ==== exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_top import exe_pkg::*; #(
    parameter int MUL_STEP = 4
) (
    input  logic      clk,
    input  logic      arst_n,
    input  exe_req_t  req,
    input  logic      flush,
    output logic      stall,
    output exe_resp_t resp,
    output hilo_t     hilo
);

    logic        done;
    alu_op_e     alu_op;
    logic [63:0] alu_result;
    logic        alu_overflow;
    logic        alu_trap;

    exe_alu #(.MUL_STEP(MUL_STEP)) exe_alu_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .req          (req),
        .flush        (flush),
        .hilo         (hilo),
        .stall        (stall),
        .done         (done),
        .out_op       (alu_op),
        .out_result   (alu_result),
        .out_overflow (alu_overflow),
        .out_trap     (alu_trap)
    );

    exe_wb exe_wb_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .done        (done),
        .flush       (flush),
        .in_op       (alu_op),
        .in_result   (alu_result),
        .in_overflow (alu_overflow),
        .in_trap     (alu_trap),
        .resp        (resp),
        .hilo        (hilo)
    );

endmodule

`default_nettype wire

// ==== exe_wb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_wb import exe_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        done,
    input  logic        flush,
    input  alu_op_e     in_op,
    input  logic [63:0] in_result,
    input  logic        in_overflow,
    input  logic        in_trap,
    output exe_resp_t   resp,
    output hilo_t       hilo
);

    logic        valid_q;
    alu_op_e     op_q;
    logic [63:0] result_q;
    logic        overflow_q;
    logic        trap_q;
    logic        take;

    assign take = done & ~flush; // flushed requests leave no trace

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
            hilo    <= '0;
        end else begin
            valid_q <= take;
            if (take && writes_hilo(in_op)) hilo <= hilo_t'(in_result);
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            op_q       <= in_op;
            result_q   <= in_result;
            overflow_q <= in_overflow;
            trap_q     <= in_trap;
        end
    end

    assign resp = '{valid: valid_q, op: op_q, result: result_q,
                    overflow: overflow_q, trap: trap_q};

    a_hilo_with_resp: assert property (@(posedge clk) disable iff (!arst_n)
        !$stable(hilo) |-> resp.valid);

endmodule

`default_nettype wire

// ==== mult_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

module mult_seq #(
    parameter int MUL_STEP = 4
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        start,
    input  logic        abort,
    input  logic        sign,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        busy,
    output logic [63:0] product
);

    localparam int STEPS = 32 / MUL_STEP;

    logic        run_q;
    logic [5:0]  cnt_q;
    logic        last;
    logic [63:0] cand_q;
    logic [31:0] plier_q;
    logic [63:0] acc_q;
    logic        neg_q;
    logic [31:0] mag_a;
    logic [31:0] mag_b;
    logic [63:0] cur_cand;
    logic [31:0] cur_plier;
    logic [63:0] next_acc;

    assign mag_a = (sign && a[31]) ? (~a + 32'd1) : a;
    assign mag_b = (sign && b[31]) ? (~b + 32'd1) : b;

    // first partial sum is taken on the start edge
    always_comb begin
        cur_cand  = start ? {32'd0, mag_a} : cand_q;
        cur_plier = start ? mag_b : plier_q;
        next_acc  = start ? 64'd0 : acc_q;
        for (int i = 0; i < MUL_STEP; i++) begin
            if (cur_plier[i]) begin
                next_acc = next_acc + (cur_cand << i);
            end
        end
    end

    assign last = (cnt_q == 6'(STEPS - 1));
    assign busy = run_q & ~last;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run_q <= 1'b0;
            cnt_q <= 6'd0;
        end else if (abort) begin
            run_q <= 1'b0;
        end else if (start) begin
            run_q <= 1'b1;
            cnt_q <= 6'd1;
        end else if (run_q) begin
            cnt_q <= cnt_q + 6'd1;
            if (last) run_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start || run_q) begin
            cand_q  <= cur_cand << MUL_STEP;
            plier_q <= cur_plier >> MUL_STEP;
            acc_q   <= next_acc;
        end
        if (start) neg_q <= sign & (a[31] ^ b[31]);
    end

    assign product = neg_q ? (~acc_q + 64'd1) : acc_q; // sign applied on the magnitude

    a_no_restart: assert property (@(posedge clk) disable iff (!arst_n) start |-> !run_q);

endmodule

`default_nettype wire

// ==== src.f ====
exe_pkg.sv
alu_logic.sv
mult_seq.sv
div_radix2.sv
exe_alu.sv
exe_wb.sv
exe_top.sv
tb_exe_top.sv

// ==== tb_exe_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exe_top import exe_pkg::*; ();

    localparam int STALL_LIMIT = 100;

    logic      clk;
    logic      arst_n;
    exe_req_t  req;
    logic      flush;
    logic      stall;
    exe_resp_t resp;
    hilo_t     hilo;

    logic      exp_valid;
    exe_resp_t exp_resp;
    exe_resp_t model_next;
    hilo_t     model_hilo;
    int        err_count;
    int        err_mark;
    int        tests_run;
    int        tests_failed;

    alu_op_e short_ops [21] = '{OP_AND, OP_OR, OP_NOR, OP_XOR, OP_ADD, OP_ADDU, OP_SUB,
                                OP_SUBU, OP_SLT, OP_SLTU, OP_SLL, OP_SLLV, OP_SRL, OP_SRLV,
                                OP_SRA, OP_SRAV, OP_LUI, OP_PASS, OP_CLO, OP_CLZ, OP_SC};
    alu_op_e edge_ops [10]  = '{OP_ADD, OP_ADDU, OP_SUB, OP_SUBU, OP_TEQ, OP_TNE,
                                OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    alu_op_e acc_ops [6]    = '{OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU, OP_MTHI, OP_MTLO};
    logic [31:0] bound_a [8] = '{32'h7fffffff, 32'h80000000, 32'h80000000, 32'h7fffffff,
                                 32'h00000000, 32'h80000000, 32'h7fffffff, 32'hffffffff};
    logic [31:0] bound_b [8] = '{32'h00000001, 32'hffffffff, 32'h00000001, 32'hffffffff,
                                 32'h00000000, 32'h80000000, 32'h7fffffff, 32'h00000001};
    logic [31:0] div_a [6]   = '{32'hfffffff9, 32'h00000007, 32'hfffffff9, 32'h80000000,
                                 32'h00001234, 32'hffff0000};
    logic [31:0] div_b [6]   = '{32'h00000002, 32'hfffffffe, 32'hfffffffe, 32'hffffffff,
                                 32'h00000000, 32'h00000000};

    exe_top #(.MUL_STEP(4)) dut_i (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .flush  (flush),
        .stall  (stall),
        .resp   (resp),
        .hilo   (hilo)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic long_op(input alu_op_e op);
        return op inside {OP_MULT, OP_MULTU, OP_MADD, OP_MADDU, OP_MSUB, OP_MSUBU,
                          OP_DIV, OP_DIVU};
    endfunction

    function automatic logic hilo_op(input alu_op_e op);
        return long_op(op) || op == OP_MTHI || op == OP_MTLO;
    endfunction

    // expected response from the instruction rules
    function automatic exe_resp_t model_resp(input exe_req_t r, input hilo_t h);
        exe_resp_t          o;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [4:0]         amt;
        logic [32:0]        wide;
        logic signed [63:0] sa64;
        logic signed [63:0] sb64;
        logic [63:0]        prod;
        int                 n;
        a = r.src_a;
        b = r.src_b;
        o = '0;
        o.valid = 1'b1;
        o.op = r.op;
        amt = (r.op inside {OP_SLLV, OP_SRLV, OP_SRAV}) ? a[4:0] : r.sa;
        sa64 = {{32{a[31]}}, a};
        sb64 = {{32{b[31]}}, b};
        if (r.op inside {OP_MULT, OP_MADD, OP_MSUB}) begin
            prod = 64'(sa64 * sb64);
        end else begin
            prod = {32'd0, a} * {32'd0, b};
        end
        case (r.op)
            OP_AND:           o.result = {32'd0, a & b};
            OP_OR:            o.result = {32'd0, a | b};
            OP_NOR:           o.result = {32'd0, ~(a | b)};
            OP_XOR:           o.result = {32'd0, a ^ b};
            OP_ADD, OP_ADDU:  o.result = {32'd0, a + b};
            OP_SUB, OP_SUBU:  o.result = {32'd0, a - b};
            OP_SLT:           o.result = {63'd0, $signed(a) < $signed(b)};
            OP_SLTU:          o.result = {63'd0, a < b};
            OP_SLL, OP_SLLV:  o.result = {32'd0, b << amt};
            OP_SRL, OP_SRLV:  o.result = {32'd0, b >> amt};
            OP_SRA, OP_SRAV:  o.result = {32'd0, 32'($signed(b) >>> amt)};
            OP_LUI:           o.result = {32'd0, b[15:0], 16'd0};
            OP_PASS:          o.result = {32'd0, a};
            OP_CLO, OP_CLZ: begin
                n = 0;
                while (n < 32 && a[31 - n] == (r.op == OP_CLO)) n++;
                o.result = 64'(n);
            end
            OP_SC:            o.result = {63'd0, r.llbit};
            OP_TEQ:           o.trap = (a == b);
            OP_TNE:           o.trap = (a != b);
            OP_TGE:           o.trap = ($signed(a) >= $signed(b));
            OP_TGEU:          o.trap = (a >= b);
            OP_TLT:           o.trap = ($signed(a) < $signed(b));
            OP_TLTU:          o.trap = (a < b);
            OP_MULT, OP_MULTU: o.result = prod;
            OP_MADD, OP_MADDU: o.result = h + prod;
            OP_MSUB, OP_MSUBU: o.result = h - prod;
            OP_DIV: begin
                if (b == 32'd0) o.result = {a, 32'hffffffff};
                else o.result = {32'(sa64 % sb64), 32'(sa64 / sb64)};
            end
            OP_DIVU: begin
                if (b == 32'd0) o.result = {a, 32'hffffffff};
                else o.result = {a % b, a / b};
            end
            OP_MTHI:          o.result = {a, h.lo};
            OP_MTLO:          o.result = {h.hi, a};
            default:          o.result = 64'd0;
        endcase
        if (r.op == OP_ADD) begin
            wide = {a[31], a} + {b[31], b};
            o.overflow = wide[32] != wide[31];
        end else if (r.op == OP_SUB) begin
            wide = {a[31], a} - {b[31], b};
            o.overflow = wide[32] != wide[31];
        end
        return o;
    endfunction

    // reference copy of the handshake and HI/LO
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_valid  <= 1'b0;
            exp_resp   <= '0;
            model_hilo <= '0;
        end else begin
            exp_valid <= req.valid && !stall && !flush;
            if (req.valid && !stall && !flush) begin
                model_next = model_resp(req, model_hilo);
                exp_resp <= model_next;
                if (hilo_op(req.op)) model_hilo <= hilo_t'(model_next.result);
            end
        end
    end

    task automatic value_fail(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
        $display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, exp);
        err_count++;
    endtask

    task automatic plain_fail(input string msg);
        $display("%0t: %s", $time, msg);
        err_count++;
    endtask

    a_resp_valid: assert property (@(negedge clk) disable iff (!arst_n)
        resp.valid == exp_valid)
        else value_fail("resp.valid", 64'(resp.valid), 64'(exp_valid));
    a_resp_op: assert property (@(negedge clk) disable iff (!arst_n)
        resp.valid |-> resp.op == exp_resp.op)
        else value_fail("resp.op", 64'(resp.op), 64'(exp_resp.op));
    a_resp_result: assert property (@(negedge clk) disable iff (!arst_n)
        resp.valid |-> resp.result == exp_resp.result)
        else value_fail("resp.result", resp.result, exp_resp.result);
    a_resp_overflow: assert property (@(negedge clk) disable iff (!arst_n)
        resp.valid |-> resp.overflow == exp_resp.overflow)
        else value_fail("resp.overflow", 64'(resp.overflow), 64'(exp_resp.overflow));
    a_resp_trap: assert property (@(negedge clk) disable iff (!arst_n)
        resp.valid |-> resp.trap == exp_resp.trap)
        else value_fail("resp.trap", 64'(resp.trap), 64'(exp_resp.trap));
    a_hilo: assert property (@(negedge clk) disable iff (!arst_n)
        hilo == model_hilo)
        else value_fail("hilo", hilo, model_hilo);
    a_short_stall: assert property (@(negedge clk) disable iff (!arst_n)
        (req.valid && !long_op(req.op)) |-> !stall)
        else plain_fail("stall went high for a single-cycle request");

    function automatic logic [31:0] shaped_word();
        logic [31:0] w;
        w = $urandom >> $urandom_range(0, 31); // long runs of leading bits
        return ($urandom_range(0, 1) == 1) ? ~w : w;
    endfunction

    // drive on a rising edge, return on the edge that accepts the request
    task automatic send_op(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                           input logic [4:0] sa, input logic ll);
        int cnt;
        req <= '{valid: 1'b1, op: op, src_a: a, src_b: b, sa: sa, llbit: ll, spare: 3'b0};
        cnt = 0;
        @(negedge clk);
        while (stall && cnt < STALL_LIMIT) begin
            cnt++;
            @(negedge clk);
        end
        if (stall) begin
            $display("timeout: stall stayed high for %0d cycles on %s", cnt, op.name());
            $display("test failed");
            $finish;
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic idle_cycles(input int n);
        req.valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic flush_long(input alu_op_e op, input logic [31:0] a, input logic [31:0] b,
                              input int delay);
        req <= '{valid: 1'b1, op: op, src_a: a, src_b: b, sa: 5'd0, llbit: 1'b0, spare: 3'b0};
        repeat (delay) @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush     <= 1'b0;
        req.valid <= 1'b0; // producer drops the cancelled request
        @(negedge clk);
        assert (!stall) else plain_fail("stall still high the cycle after flush");
        @(posedge clk);
    endtask

    task automatic close_test(input string name);
        int n;
        n = err_count - err_mark;
        tests_run++;
        if (n != 0) tests_failed++;
        $display("%-28s %0d errors", name, n);
        err_mark = err_count;
    endtask

    initial begin
        int      i;
        int      j;
        alu_op_e op;
        void'($urandom(32'h6151));
        arst_n       = 1'b0;
        req          = '0;
        flush        = 1'b0;
        err_count    = 0;
        err_mark     = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        assert (!resp.valid && !stall && hilo == '0)
            else plain_fail("outputs not idle after reset");
        close_test("reset state");
        @(posedge clk);

        for (i = 0; i < 80; i++) begin
            op = short_ops[$urandom_range(0, 20)];
            send_op(op, shaped_word(), $urandom, 5'($urandom), 1'($urandom));
        end
        send_op(OP_CLZ, 32'h00000000, 32'd0, 5'd0, 1'b0); // all bits match
        send_op(OP_CLO, 32'hffffffff, 32'd0, 5'd0, 1'b0);
        idle_cycles(2);
        close_test("single-cycle ops");

        for (i = 0; i < 8; i++) begin
            for (j = 0; j < 10; j++) begin
                send_op(edge_ops[j], bound_a[i], bound_b[i], 5'd0, 1'b0);
            end
        end
        idle_cycles(2);
        close_test("overflow and trap");

        send_op(OP_MULT, $urandom, $urandom, 5'd0, 1'b0);
        send_op(OP_MULTU, $urandom, $urandom, 5'd0, 1'b0);
        for (i = 0; i < 16; i++) begin
            op = acc_ops[$urandom_range(0, 5)];
            send_op(op, shaped_word(), $urandom, 5'd0, 1'b0);
        end
        idle_cycles(2);
        close_test("multiply and accumulate");

        for (i = 0; i < 6; i++) begin
            send_op(OP_DIV, div_a[i], div_b[i], 5'd0, 1'b0);
            send_op(OP_DIVU, div_a[i], div_b[i], 5'd0, 1'b0);
        end
        for (i = 0; i < 8; i++) begin
            op = ($urandom_range(0, 1) == 1) ? OP_DIV : OP_DIVU;
            send_op(op, $urandom, shaped_word(), 5'd0, 1'b0);
        end
        idle_cycles(2);
        close_test("divide");

        send_op(OP_MTHI, 32'h11112222, 32'd0, 5'd0, 1'b0);
        send_op(OP_MTLO, 32'h33334444, 32'd0, 5'd0, 1'b0);
        flush_long(OP_MADD, $urandom, $urandom, 3);
        send_op(OP_MULTU, $urandom, $urandom, 5'd0, 1'b0); // engines back to idle
        flush_long(OP_DIV, $urandom, $urandom, 10);
        send_op(OP_DIVU, $urandom, $urandom, 5'd0, 1'b0);
        idle_cycles(2);
        close_test("flush");

        send_op(OP_ADD, $urandom, $urandom, 5'd0, 1'b0);
        send_op(OP_MULT, $urandom, $urandom, 5'd0, 1'b0);
        send_op(OP_XOR, $urandom, $urandom, 5'd0, 1'b0);
        send_op(OP_DIV, $urandom, shaped_word(), 5'd0, 1'b0);
        send_op(OP_SUB, $urandom, $urandom, 5'd0, 1'b0);
        send_op(OP_MTLO, $urandom, 32'd0, 5'd0, 1'b0);
        send_op(OP_MSUBU, $urandom, $urandom, 5'd0, 1'b0);
        send_op(OP_OR, $urandom, $urandom, 5'd0, 1'b0);
        idle_cycles(3);
        close_test("back-to-back");

        $display("tests %0d, failing %0d, errors %0d", tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
